// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module data_mem_tb -f list.f -o sim_data_mem
	./obj_dir/sim_data_mem +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "Test did not complete"; exit 1)
	@echo "Test passed"

clean:
	rm -rf obj_dir $(LOG)

// File: hw/bytewrite_ram_32bits.sv
/* Word RAM with per-byte write enables, one cycle read latency.
   Each access returns the old word at its address before the write lands. */
`timescale 1ns/1ns
`default_nettype none

module bytewrite_ram_32bits #(
  parameter int unsigned SIZE       = 1024,
  parameter int unsigned ADDR_WIDTH = 10
) (
  input logic       clk,
  ram_port_if.slave port
);

  mem_pkg::word_t        mem [SIZE];
  logic [ADDR_WIDTH-1:0] addr;
  mem_pkg::word_t        mask;

  assign addr = port.addr;
  assign mask = mem_pkg::lane_mask(port.we);

  always_ff @(posedge clk) begin
    if (port.in_range) begin
      // Old word out, then merge the enabled lanes
      port.dout <= mem[addr];
      if (port.we != '0) begin
        mem[addr] <= (mem[addr] & ~mask) | (port.din & mask);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/data_mem_top.sv
/* Data memory of the load/store core. Byte, halfword and word accesses
   go through the aligners to a byte-write RAM, load data returns a cycle later. */
`timescale 1ns/1ns
`default_nettype none

module data_mem_top #(
  parameter int unsigned SIZE       = 1024,
  parameter int unsigned ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic                  store,
  input  lsu_pkg::size_e        size,
  input  logic                  unsigned_load,
  input  logic [ADDR_WIDTH+1:0] byte_addr,
  input  mem_pkg::word_t        store_data,
  output mem_pkg::word_t        load_data,
  output logic                  load_valid,
  output logic                  misaligned
);

  logic             load_ok;
  lsu_pkg::offset_t lane_off;
  lsu_pkg::size_e   lane_size;

  ram_port_if #(.SIZE(SIZE), .ADDR_WIDTH(ADDR_WIDTH)) ram_port ();

  store_align #(.SIZE(SIZE), .ADDR_WIDTH(ADDR_WIDTH)) i_store_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .store      (store),
    .size       (size),
    .byte_addr  (byte_addr),
    .store_data (store_data),
    .port       (ram_port.master),
    .load_ok    (load_ok),
    .lane_off   (lane_off),
    .lane_size  (lane_size),
    .misaligned (misaligned)
  );

  bytewrite_ram_32bits #(.SIZE(SIZE), .ADDR_WIDTH(ADDR_WIDTH)) i_ram (
    .clk  (clk),
    .port (ram_port.slave)
  );

  // Read word goes straight to the load aligner
  load_align i_load_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_ok       (load_ok),
    .lane_off      (lane_off),
    .lane_size     (lane_size),
    .unsigned_load (unsigned_load),
    .dout          (ram_port.dout),
    .load_data     (load_data),
    .load_valid    (load_valid)
  );

endmodule

`default_nettype wire

// File: hw/load_align.sv
/* Load return path. Holds the lane selection of a load while the RAM reads,
   then shifts the returned word down and zero or sign extends it. */
`timescale 1ns/1ns
`default_nettype none

module load_align (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_ok,
  input  lsu_pkg::offset_t lane_off,
  input  lsu_pkg::size_e   lane_size,
  input  logic             unsigned_load,
  input  mem_pkg::word_t   dout,
  output mem_pkg::word_t   load_data,
  output logic             load_valid
);

  localparam int unsigned WORD_W = $bits(mem_pkg::word_t);

  lsu_pkg::offset_t off_q;
  lsu_pkg::size_e   size_q;
  logic             uns_q;
  logic             pend_q;
  mem_pkg::word_t   shifted;
  mem_pkg::word_t   ext;
  logic             sign;

  // Lane info of the load now at the RAM
  always_ff @(posedge clk) begin
    if (load_ok) begin
      off_q  <= lane_off;
      size_q <= lane_size;
      uns_q  <= unsigned_load;
    end
  end

  always_comb begin
    shifted = dout >> (off_q * mem_pkg::BYTE_W);
    case (size_q)
      lsu_pkg::size_word: begin
        sign = 1'b0;
        ext  = shifted;
      end
      lsu_pkg::size_half: begin
        sign = !uns_q && shifted[lsu_pkg::HALF_W-1];
        ext  = {{(WORD_W - lsu_pkg::HALF_W){sign}}, shifted[lsu_pkg::HALF_W-1:0]};
      end
      default: begin
        sign = !uns_q && shifted[mem_pkg::BYTE_W-1];
        ext  = {{(WORD_W - mem_pkg::BYTE_W){sign}}, shifted[mem_pkg::BYTE_W-1:0]};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q     <= 1'b0;
      load_valid <= 1'b0;
      load_data  <= '0;
    end else begin
      pend_q     <= load_ok;
      load_valid <= pend_q;
      // Result stays put until the next load returns
      if (pend_q) begin
        load_data <= ext;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
/* Access size encoding and field widths for the load/store aligners.
   Store and load alignment share the alignment rule defined here. */
`default_nettype none

package lsu_pkg;

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } size_e;

  // Byte offset inside a word
  typedef logic [1:0] offset_t;

  // Width of the field a halfword load extends from
  localparam int unsigned HALF_W = 16;

  // Byte accesses are always aligned
  function automatic logic is_aligned(size_e size, offset_t off);
    case (size)
      size_half: return ~off[0];
      size_word: return off == 2'b00;
      default:   return 1'b1;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: hw/mem_pkg.sv
/* RAM geometry and lane helpers for the data memory.
   Used by the RAM port interface, the RAM and the load/store aligners. */
`default_nettype none

package mem_pkg;

  // Four byte lanes per 32-bit word
  localparam int unsigned LANES  = 4;
  localparam int unsigned BYTE_W = 8;

  typedef logic [LANES*BYTE_W-1:0] word_t;

  // One enable per lane, bit 0 is the lowest byte
  typedef logic [LANES-1:0] be_t;

  // Expand byte enables into a bit mask over the whole word
  function automatic word_t lane_mask(be_t be);
    word_t mask;
    for (int i = 0; i < LANES; i++) begin
      mask[i*BYTE_W +: BYTE_W] = {BYTE_W{be[i]}};
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: hw/ram_port_if.sv
/* Port bundle between the store aligner and the byte-write RAM.
   The aligner drives address, enables and data, the RAM returns the read word. */
`timescale 1ns/1ns
`default_nettype none

interface ram_port_if #(
  parameter int unsigned SIZE       = 1024,
  parameter int unsigned ADDR_WIDTH = 10
);

  mem_pkg::be_t          we;
  logic [ADDR_WIDTH-1:0] addr;
  mem_pkg::word_t        din;
  mem_pkg::word_t        dout;

  // Address falls inside the array
  logic in_range;
  assign in_range = (32'(addr) < SIZE);

  modport master (output we, output addr, output din);
  modport slave  (input we, input addr, input din, input in_range, output dout);

endinterface

`default_nettype wire

// File: hw/store_align.sv
/* Request decoder for the data memory. Checks alignment, drives the RAM port
   with enables and replicated data, and hands load lane info to the load aligner. */
`timescale 1ns/1ns
`default_nettype none

module store_align #(
  parameter int unsigned SIZE       = 1024,
  parameter int unsigned ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic                  store,
  input  lsu_pkg::size_e        size,
  input  logic [ADDR_WIDTH+1:0] byte_addr,
  input  mem_pkg::word_t        store_data,
  ram_port_if.master            port,
  output logic                  load_ok,
  output lsu_pkg::offset_t      lane_off,
  output lsu_pkg::size_e        lane_size,
  output logic                  misaligned
);

  lsu_pkg::offset_t      off;
  logic [ADDR_WIDTH-1:0] word_addr;
  logic                  aligned;
  logic                  hit;
  mem_pkg::be_t          be;
  logic                  mis_d;
  logic                  mis_q;

  assign off       = byte_addr[1:0];
  assign word_addr = byte_addr[ADDR_WIDTH+1:2];
  assign aligned   = lsu_pkg::is_aligned(size, off);
  // Words past the end of the array are never accessed
  assign hit       = (32'(word_addr) < SIZE);

  always_comb begin
    case (size)
      lsu_pkg::size_word: begin
        be       = '1;
        port.din = store_data;
      end
      lsu_pkg::size_half: begin
        be       = mem_pkg::be_t'(4'b0011 << off);
        port.din = {(mem_pkg::LANES / 2){store_data[lsu_pkg::HALF_W-1:0]}};
      end
      default: begin
        be       = mem_pkg::be_t'(4'b0001 << off);
        port.din = {mem_pkg::LANES{store_data[mem_pkg::BYTE_W-1:0]}};
      end
    endcase
  end

  // Store takes the port when both strobes are up
  assign port.addr = word_addr;
  assign port.we   = (store && aligned && hit) ? be : '0;
  assign load_ok   = load && !store && aligned && hit;
  assign lane_off  = off;
  assign lane_size = size;

  assign mis_d = (load || store) && !aligned;

  // Two stages so the flag lines up with load_valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mis_q      <= 1'b0;
      misaligned <= 1'b0;
    end else begin
      mis_q      <= mis_d;
      misaligned <= mis_q;
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/mem_pkg.sv
hw/lsu_pkg.sv
hw/ram_port_if.sv
hw/bytewrite_ram_32bits.sv
hw/store_align.sv
hw/load_align.sv
hw/data_mem_top.sv
verif/bytewrite_ram_properties.sv
verif/data_mem_tb.sv

// File: verif/bytewrite_ram_properties.sv
/* Bound checker for the byte-write RAM port. Keeps a shadow copy of the array
   and compares every read word with it, fail_count tallies failed properties. */
`timescale 1ns/1ns
`default_nettype none

module bytewrite_ram_properties #(
  parameter int unsigned SIZE       = 1024,
  parameter int unsigned ADDR_WIDTH = 10
) (
  input logic                  clk,
  input mem_pkg::be_t          we,
  input logic [ADDR_WIDTH-1:0] addr,
  input mem_pkg::word_t        din,
  input mem_pkg::word_t        dout
);

  mem_pkg::word_t shadow [SIZE];
  mem_pkg::word_t exp_q;
  mem_pkg::word_t mask;
  logic           primed_q   = 1'b0;
  int             fail_count = 0;

  assign mask = mem_pkg::lane_mask(we);

  // Shadow copy, old word out and then the enabled lanes merged
  always @(posedge clk) begin
    primed_q <= 1'b1;
    if (32'(addr) < SIZE) begin
      exp_q        <= shadow[addr];
      shadow[addr] <= (shadow[addr] & ~mask) | (din & mask);
    end
  end

  a_inputs_known: assert property (@(posedge clk) !$isunknown({we, addr, din}))
    else begin
      fail_count = fail_count + 1;
      $error("RAM port input is unknown");
    end

  a_addr_in_range: assert property (@(posedge clk) 32'(addr) < SIZE)
    else begin
      fail_count = fail_count + 1;
      $error("RAM word address is outside the array");
    end

  a_read_data: assert property (@(posedge clk) primed_q |-> dout === exp_q)
    else begin
      fail_count = fail_count + 1;
      $error("RAM read word differs from the shadow copy");
    end

endmodule

bind bytewrite_ram_32bits bytewrite_ram_properties #(
  .SIZE       (SIZE),
  .ADDR_WIDTH (ADDR_WIDTH)
) i_props (
  .clk  (clk),
  .we   (port.we),
  .addr (port.addr),
  .din  (port.din),
  .dout (port.dout)
);

`default_nettype wire

// File: verif/data_mem_tb.sv
/* Testbench for the data memory. Applies a table of loads and stores and checks
   load data, load_valid and misaligned against a byte-array model. */
`timescale 1ns/1ns
`default_nettype none

module data_mem_tb;

  localparam int unsigned SIZE       = 1024;
  localparam int unsigned ADDR_WIDTH = 10;

  // Bit 0 raises load, bit 1 raises store
  localparam logic [1:0] op_idle  = 2'b00;
  localparam logic [1:0] op_load  = 2'b01;
  localparam logic [1:0] op_store = 2'b10;
  localparam logic [1:0] op_both  = 2'b11;

  typedef logic [ADDR_WIDTH+1:0] baddr_t;

  typedef struct {
    logic [1:0]     op;
    lsu_pkg::size_e sz;
    logic           uns;
    baddr_t         addr;
    logic [31:0]    data;
    logic [31:0]    exp_data;
    logic           exp_valid;
    logic           exp_mis;
  } vector_t;

  logic           clk;
  logic           rst_n;
  logic           load;
  logic           store;
  lsu_pkg::size_e size;
  logic           unsigned_load;
  baddr_t         byte_addr;
  logic [31:0]    store_data;
  logic [31:0]    load_data;
  logic           load_valid;
  logic           misaligned;

  vector_t     vectors[$];
  logic [7:0]  ref_mem [SIZE*4];
  logic [31:0] held_data;
  int          seed = 32'h1a59;
  int          cycles = 0;
  int          limit_cycles = 0;
  int          data_errors = 0;
  int          valid_errors = 0;
  int          mis_errors = 0;
  int          ram_errors;

  data_mem_top #(.SIZE(SIZE), .ADDR_WIDTH(ADDR_WIDTH)) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .store         (store),
    .size          (size),
    .unsigned_load (unsigned_load),
    .byte_addr     (byte_addr),
    .store_data    (store_data),
    .load_data     (load_data),
    .load_valid    (load_valid),
    .misaligned    (misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit_cycles != 0 && cycles >= limit_cycles) begin
      $display("Timeout: the run did not end within %0d cycles", limit_cycles);
      $display("Something failed");
      $finish;
    end
  end

  // Halfwords need an even offset, words offset zero
  function automatic logic misaligned_access(lsu_pkg::size_e sz, baddr_t addr);
    if (sz == lsu_pkg::size_half) return addr[0];
    if (sz == lsu_pkg::size_word) return addr[1:0] != 2'b00;
    return 1'b0;
  endfunction

  task automatic model_store(input lsu_pkg::size_e sz, input baddr_t addr,
                             input logic [31:0] data);
    case (sz)
      lsu_pkg::size_byte: ref_mem[addr] = data[7:0];
      lsu_pkg::size_half: begin
        ref_mem[addr]         = data[7:0];
        ref_mem[addr + 12'd1] = data[15:8];
      end
      default: begin
        for (int b = 0; b < 4; b++) ref_mem[addr + baddr_t'(b)] = data[b*8 +: 8];
      end
    endcase
  endtask

  // Little endian lanes, sign taken from the top bit of the field
  function automatic logic [31:0] model_load(lsu_pkg::size_e sz, logic uns, baddr_t addr);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = ref_mem[addr];
    b1 = ref_mem[addr + 12'd1];
    case (sz)
      lsu_pkg::size_byte: return {{24{b0[7] & ~uns}}, b0};
      lsu_pkg::size_half: return {{16{b1[7] & ~uns}}, b1, b0};
      default: return {ref_mem[addr + 12'd3], ref_mem[addr + 12'd2], b1, b0};
    endcase
  endfunction

  task automatic add_entry(input logic [1:0] op, input lsu_pkg::size_e sz, input logic uns,
                           input baddr_t addr, input logic [31:0] data);
    vector_t v;
    logic    mis;
    mis = misaligned_access(sz, addr);
    v.op = op;
    v.sz = sz;
    v.uns = uns;
    v.addr = addr;
    v.data = data;
    v.exp_valid = 1'b0;
    // A store takes the cycle and the load is dropped
    if (op[1] && !mis) begin
      model_store(sz, addr, data);
    end else if (op == op_load && !mis) begin
      held_data = model_load(sz, uns, addr);
      v.exp_valid = 1'b1;
    end
    v.exp_data = held_data;
    v.exp_mis = (op != op_idle) && mis;
    vectors.push_back(v);
  endtask

  task automatic build_vectors();
    held_data = '0;
    for (int w = 0; w < 16; w++) add_entry(op_store, lsu_pkg::size_word, 1'b0,
                                           baddr_t'(w * 4), $random(seed));
    add_entry(op_store, lsu_pkg::size_word, 1'b0, 12'h040, 32'hcafe_f00d);
    add_entry(op_idle, lsu_pkg::size_word, 1'b0, 12'h000, 32'h0);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h040, 32'h0);
    // Word load after each byte store shows which lanes moved
    for (int b = 0; b < 4; b++) begin
      add_entry(op_store, lsu_pkg::size_byte, 1'b0,
                baddr_t'(12'h010 + b), 32'h1234_56a0 + b);
      add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h010, 32'h0);
    end
    // Fields with the top bit set
    add_entry(op_store, lsu_pkg::size_word, 1'b0, 12'h020, 32'hf08c_8193);
    add_entry(op_load, lsu_pkg::size_byte, 1'b0, 12'h021, 32'h0);
    add_entry(op_load, lsu_pkg::size_byte, 1'b1, 12'h021, 32'h0);
    add_entry(op_load, lsu_pkg::size_half, 1'b0, 12'h022, 32'h0);
    add_entry(op_load, lsu_pkg::size_half, 1'b1, 12'h020, 32'h0);
    add_entry(op_store, lsu_pkg::size_half, 1'b0, 12'h026, 32'h5555_9abc);
    add_entry(op_load, lsu_pkg::size_half, 1'b0, 12'h026, 32'h0);
    add_entry(op_store, lsu_pkg::size_half, 1'b0, 12'h031, 32'hffff_ffff);
    add_entry(op_store, lsu_pkg::size_word, 1'b0, 12'h032, 32'hffff_ffff);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h030, 32'h0);
    add_entry(op_load, lsu_pkg::size_half, 1'b0, 12'h033, 32'h0);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h031, 32'h0);
    // Load right behind a store to the same word
    add_entry(op_store, lsu_pkg::size_word, 1'b0, 12'h034, 32'h1357_9bdf);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h034, 32'h0);
    add_entry(op_both, lsu_pkg::size_word, 1'b0, 12'h038, 32'h0bad_beef);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h038, 32'h0);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h000, 32'h0);
    add_entry(op_load, lsu_pkg::size_word, 1'b0, 12'h004, 32'h0);
    add_entry(op_load, lsu_pkg::size_byte, 1'b1, 12'h00d, 32'h0);
  endtask

  task automatic check_entry(input vector_t v, input int idx);
    assert (load_valid === v.exp_valid) else begin
      valid_errors++;
      $display("ERROR at %0t: entry %0d load_valid %b, expected %b",
               $time, idx, load_valid, v.exp_valid);
    end
    assert (load_data === v.exp_data) else begin
      data_errors++;
      $display("ERROR at %0t: entry %0d load_data %h, expected %h",
               $time, idx, load_data, v.exp_data);
    end
    assert (misaligned === v.exp_mis) else begin
      mis_errors++;
      $display("ERROR at %0t: entry %0d misaligned %b, expected %b",
               $time, idx, misaligned, v.exp_mis);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    load = 1'b0;
    store = 1'b0;
    size = lsu_pkg::size_byte;
    unsigned_load = 1'b0;
    byte_addr = '0;
    store_data = '0;
    build_vectors();
    limit_cycles = vectors.size() * 4 + 50;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Results of an entry show up two edges after it is driven
    for (int i = 0; i < vectors.size() + 2; i++) begin
      @(posedge clk);
      if (i < vectors.size()) begin
        load          <= vectors[i].op[0];
        store         <= vectors[i].op[1];
        size          <= vectors[i].sz;
        unsigned_load <= vectors[i].uns;
        byte_addr     <= vectors[i].addr;
        store_data    <= vectors[i].data;
      end else begin
        load  <= 1'b0;
        store <= 1'b0;
      end
      @(negedge clk);
      if (i >= 2) check_entry(vectors[i-2], i - 2);
    end
    ram_errors = i_dut.i_ram.i_props.fail_count;
    $display("Errors: load_data %0d, load_valid %0d, misaligned %0d, RAM port %0d",
             data_errors, valid_errors, mis_errors, ram_errors);
    if (data_errors + valid_errors + mis_errors + ram_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
